// ==== src/mx_params.svh ====
// Matrix coprocessor sizes
`ifndef MX_PARAMS_SVH
`define MX_PARAMS_SVH

// Register file geometry
`define MX_N_REGS 8
`define MX_N_ROWS 4
`define MX_RLEN 128

// Offload ID width
`define MX_ID_W 4

// Queue depths
`define MX_IBUF_DEPTH 4
`define MX_RES_DEPTH 4

`endif

// ==== src/mx_pkg.sv ====
// Matrix coprocessor shared types
`default_nettype none

`include "mx_params.svh"

package mx_pkg;

  // ******************************
  // Data types
  // ******************************

  typedef logic [$clog2(`MX_N_REGS)-1:0] reg_idx_t;  // Matrix register index
  typedef logic [$clog2(`MX_N_ROWS)-1:0] row_idx_t;  // Row within a register
  typedef logic [`MX_RLEN-1:0] row_t;
  typedef logic [`MX_ID_W-1:0] id_t;

  typedef enum logic {
    FILL_ZERO  = 1'b0,
    FILL_BCAST = 1'b1  // Scalar copied across the row
  } fill_op_e;

  // ******************************
  // Encodings
  // ******************************

  localparam logic [6:0] OPC_MATRIX = 7'b0101011;
  localparam logic [2:0] F3_ZERO = 3'b000;
  localparam logic [2:0] F3_BCAST = 3'b001;

endpackage

`default_nettype wire

// ==== src/mx_issue_buffer.sv ====
// Issue decode and input buffer
`timescale 1ns/1ps
`default_nettype none

`include "mx_params.svh"

module mx_issue_buffer (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 issue_valid_i,
  input  logic [31:0]                          issue_instr_i,
  input  logic [31:0]                          issue_rs1_i,
  input  mx_pkg::id_t                          issue_id_i,
  input  logic                                 pop_i,
  output logic                                 issue_ready_o,
  output logic                                 issue_accept_o,
  output logic                                 push_o,
  output logic                                 buf_valid_o,
  output logic [$clog2(`MX_IBUF_DEPTH+1)-1:0]  buf_count_o,
  output mx_pkg::fill_op_e                     buf_op_o,
  output mx_pkg::reg_idx_t                     buf_md_o,
  output logic [31:0]                          buf_rs1_o,
  output mx_pkg::id_t                          buf_id_o
);
  import mx_pkg::*;

  localparam int unsigned depth = `MX_IBUF_DEPTH;
  localparam int unsigned ptr_w = $clog2(depth);
  localparam int unsigned cnt_w = $clog2(depth + 1);

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  fill_op_e         dec_op;
  reg_idx_t         dec_md;
  fill_op_e         op_mem [depth];
  reg_idx_t         md_mem [depth];
  logic [31:0]      rs1_mem [depth];
  id_t              id_mem [depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;

  // ******************************
  // Decode
  // ******************************

  assign opcode = issue_instr_i[6:0];
  assign funct3 = issue_instr_i[14:12];
  assign dec_md = issue_instr_i[9:7];
  assign dec_op = (funct3 == F3_BCAST) ? FILL_BCAST : FILL_ZERO;

  // Only the two fill forms are ours
  assign issue_accept_o = (opcode == OPC_MATRIX) && ((funct3 == F3_ZERO) || (funct3 == F3_BCAST));
  assign issue_ready_o  = (count_q != cnt_w'(depth));
  assign push_o         = issue_valid_i && issue_ready_o && issue_accept_o;

  // ******************************
  // Circular buffer
  // ******************************

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_o) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push_o, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_o) begin
      op_mem[wr_ptr_q]  <= dec_op;
      md_mem[wr_ptr_q]  <= dec_md;
      rs1_mem[wr_ptr_q] <= issue_rs1_i;
      id_mem[wr_ptr_q]  <= issue_id_i;
    end
  end

  // Fall-through when empty
  assign buf_valid_o = (count_q != '0) || push_o;
  assign buf_count_o = count_q;

  always_comb begin
    if (count_q == '0) begin
      buf_op_o  = dec_op;
      buf_md_o  = dec_md;
      buf_rs1_o = issue_rs1_i;
      buf_id_o  = issue_id_i;
    end else begin
      buf_op_o  = op_mem[rd_ptr_q];
      buf_md_o  = md_mem[rd_ptr_q];
      buf_rs1_o = rs1_mem[rd_ptr_q];
      buf_id_o  = id_mem[rd_ptr_q];
    end
  end

  // Dispatcher only pops stored, committed entries
  a_no_overrun: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pop_i |-> count_q != '0) and (push_o |-> count_q != cnt_w'(depth)))
    else $error("issue buffer overrun or underrun");

endmodule

`default_nettype wire

// ==== src/mx_dispatcher.sv ====
// Commit tracking and dispatch
`timescale 1ns/1ps
`default_nettype none

`include "mx_params.svh"

module mx_dispatcher (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 commit_valid_i,
  input  logic                                 push_i,
  input  logic                                 buf_valid_i,
  input  logic [$clog2(`MX_IBUF_DEPTH+1)-1:0]  buf_count_i,
  input  logic                                 unit_busy_i,
  input  logic                                 has_slot_i,
  output logic                                 pop_o,
  output logic                                 start_o
);

  localparam int unsigned cnt_w = $clog2(`MX_IBUF_DEPTH + 1);

  logic [cnt_w-1:0] uncommitted_q;
  logic             head_committed;

  // ******************************
  // Uncommitted counter
  // ******************************

  // Every uncommitted instruction still sits in the buffer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      uncommitted_q <= '0;
    end else begin
      case ({commit_valid_i, push_i})
        2'b01:   uncommitted_q <= uncommitted_q + 1'b1;  // New offer
        2'b10:   uncommitted_q <= uncommitted_q - 1'b1;  // Oldest committed
        default: uncommitted_q <= uncommitted_q;
      endcase
    end
  end

  // ******************************
  // Dispatch
  // ******************************

  // More entries than uncommitted ones means the head is committed
  assign head_committed = (buf_count_i > uncommitted_q);

  // Result queue slot is checked here so done never drops
  assign start_o = buf_valid_i && head_committed && !unit_busy_i && has_slot_i;
  assign pop_o   = start_o;  // Head leaves as it starts

  a_commit_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_valid_i |-> uncommitted_q != '0)
    else $error("commit with no uncommitted instruction");

endmodule

`default_nettype wire

// ==== src/mx_row_fill_unit.sv ====
// Matrix row fill unit
`timescale 1ns/1ps
`default_nettype none

`include "mx_params.svh"

module mx_row_fill_unit (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              start_i,
  input  mx_pkg::fill_op_e  op_i,
  input  mx_pkg::reg_idx_t  md_i,
  input  logic [31:0]       rs1_i,
  input  mx_pkg::id_t       id_i,
  input  logic              clr_ready_i,
  output logic              busy_o,
  output logic              clr_valid_o,
  output mx_pkg::reg_idx_t  clr_reg_o,
  output mx_pkg::row_idx_t  clr_row_o,
  output mx_pkg::row_t      clr_data_o,
  output logic              done_o,
  output mx_pkg::id_t       done_id_o
);
  import mx_pkg::*;

  logic        busy_q;
  logic        done_q;
  row_idx_t    row_q;
  fill_op_e    op_q;
  reg_idx_t    md_q;
  logic [31:0] rs1_q;
  id_t         id_q;
  logic        xfer;
  logic        last_row;

  assign xfer     = busy_q && clr_ready_i;  // Row accepted by register file
  assign last_row = (row_q == row_idx_t'(`MX_N_ROWS - 1));

  // ******************************
  // Row sequencing
  // ******************************

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      row_q  <= '0;
    end else begin
      done_q <= xfer && last_row;
      if (start_i) begin
        busy_q <= 1'b1;
        row_q  <= '0;
      end else if (xfer) begin
        if (last_row) busy_q <= 1'b0;  // Drops with the done pulse
        row_q <= row_q + 1'b1;
      end
    end
  end

  // Instruction latched for the whole fill
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      op_q  <= op_i;
      md_q  <= md_i;
      rs1_q <= rs1_i;
      id_q  <= id_i;
    end
  end

  assign busy_o      = busy_q;
  assign clr_valid_o = busy_q;
  assign clr_reg_o   = md_q;
  assign clr_row_o   = row_q;
  assign clr_data_o  = (op_q == FILL_BCAST) ? {(`MX_RLEN / 32){rs1_q}} : '0;
  assign done_o      = done_q;
  assign done_id_o   = id_q;

  a_no_start_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> !busy_q)
    else $error("row fill started while busy");

endmodule

`default_nettype wire

// ==== src/mx_result_queue.sv ====
// Finished ID queue
`timescale 1ns/1ps
`default_nettype none

`include "mx_params.svh"

module mx_result_queue (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         done_i,
  input  mx_pkg::id_t  done_id_i,
  input  logic         result_ready_i,
  output logic         result_valid_o,
  output mx_pkg::id_t  result_id_o,
  output logic         has_slot_o
);
  import mx_pkg::*;

  localparam int unsigned depth = `MX_RES_DEPTH;
  localparam int unsigned ptr_w = $clog2(depth);
  localparam int unsigned cnt_w = $clog2(depth + 1);

  id_t              id_mem [depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             pop;

  assign pop = result_valid_o && result_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (done_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (done_i && !pop) count_q <= count_q + 1'b1;
      else if (pop && !done_i) count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (done_i) id_mem[wr_ptr_q] <= done_id_i;
  end

  assign result_valid_o = (count_q != '0);
  assign result_id_o    = id_mem[rd_ptr_q];
  assign has_slot_o     = (count_q < cnt_w'(depth - 1));  // One slot kept for the unit

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |-> count_q != cnt_w'(depth))
    else $error("result queue overflow");

endmodule

`default_nettype wire

// ==== src/mx_top.sv ====
// Matrix fill coprocessor top
`timescale 1ns/1ps
`default_nettype none

`include "mx_params.svh"

module mx_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              issue_valid_i,
  output logic              issue_ready_o,
  input  logic [31:0]       issue_instr_i,
  input  logic [31:0]       issue_rs1_i,
  input  mx_pkg::id_t       issue_id_i,
  output logic              issue_accept_o,
  input  logic              commit_valid_i,
  output logic              clr_valid_o,
  input  logic              clr_ready_i,
  output mx_pkg::reg_idx_t  clr_reg_o,
  output mx_pkg::row_idx_t  clr_row_o,
  output mx_pkg::row_t      clr_data_o,
  output logic              result_valid_o,
  input  logic              result_ready_i,
  output mx_pkg::id_t       result_id_o
);
  import mx_pkg::*;

  // ******************************
  // Stage wiring
  // ******************************

  logic                                push;
  logic                                buf_valid;
  logic [$clog2(`MX_IBUF_DEPTH+1)-1:0] buf_count;
  fill_op_e                            buf_op;
  reg_idx_t                            buf_md;
  logic [31:0]                         buf_rs1;
  id_t                                 buf_id;
  logic                                pop;
  logic                                start;
  logic                                busy;
  logic                                done;
  id_t                                 done_id;
  logic                                has_slot;

  mx_issue_buffer issue_buffer_i (
    .clk_i, .rst_ni, .issue_valid_i, .issue_instr_i, .issue_rs1_i, .issue_id_i,
    .pop_i(pop), .issue_ready_o, .issue_accept_o, .push_o(push),
    .buf_valid_o(buf_valid), .buf_count_o(buf_count), .buf_op_o(buf_op),
    .buf_md_o(buf_md), .buf_rs1_o(buf_rs1), .buf_id_o(buf_id)
  );

  mx_dispatcher dispatcher_i (
    .clk_i, .rst_ni, .commit_valid_i, .push_i(push), .buf_valid_i(buf_valid),
    .buf_count_i(buf_count), .unit_busy_i(busy), .has_slot_i(has_slot),
    .pop_o(pop), .start_o(start)
  );

  mx_row_fill_unit row_fill_i (
    .clk_i, .rst_ni, .start_i(start), .op_i(buf_op), .md_i(buf_md), .rs1_i(buf_rs1),
    .id_i(buf_id), .clr_ready_i, .busy_o(busy), .clr_valid_o, .clr_reg_o, .clr_row_o,
    .clr_data_o, .done_o(done), .done_id_o(done_id)
  );

  mx_result_queue result_queue_i (
    .clk_i, .rst_ni, .done_i(done), .done_id_i(done_id), .result_ready_i,
    .result_valid_o, .result_id_o, .has_slot_o(has_slot)
  );

endmodule

`default_nettype wire

// ==== dv/tb_mx.sv ====
// Matrix fill coprocessor testbench
`timescale 1ns/1ps
`default_nettype none

`include "mx_params.svh"

module tb_mx;
  import mx_pkg::*;

  localparam int unsigned clk_period = 4;
  localparam int unsigned n_instr = 100;  // Offers over all tests, with margin
  localparam int unsigned rep = `MX_RLEN / 32;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        issue_valid_i;
  logic        issue_ready_o;
  logic [31:0] issue_instr_i;
  logic [31:0] issue_rs1_i;
  id_t         issue_id_i;
  logic        issue_accept_o;
  logic        commit_valid_i;
  logic        clr_valid_o;
  logic        clr_ready_i;
  reg_idx_t    clr_reg_o;
  row_idx_t    clr_row_o;
  row_t        clr_data_o;
  logic        result_valid_o;
  logic        result_ready_i;
  id_t         result_id_o;

  // ******************************
  // Reference model state
  // ******************************

  logic [15:0] lfsr = 16'd43949;
  reg_idx_t    md_qm [$];    // Accepted, rows still owed
  row_t        data_qm [$];
  id_t         id_qm [$];    // Accepted, result still owed
  int unsigned row_cnt = 0;
  int          live_cnt = 0; // Committed and not yet returned
  int unsigned n_accepted = 0;
  int unsigned n_committed = 0;
  int unsigned n_checks = 0;
  int unsigned n_tests = 0;
  int unsigned errors = 0;
  logic        exp_accept = 1'b0;
  logic        rows_pend = 1'b0;
  logic        res_pend = 1'b0;
  logic        model_idle = 1'b1;
  reg_idx_t    exp_md = '0;
  row_idx_t    exp_row = '0;
  row_t        exp_data = '0;
  id_t         exp_id = '0;
  logic        commit_en = 1'b1;
  int unsigned bp_mode = 0;  // 0 always ready, 1 random, 2 held low
  logic        saw_full = 1'b0;
  id_t         id_ctr = '0;

  always #(clk_period / 2) clk_i = ~clk_i;

  mx_top dut_i (
    .clk_i, .rst_ni, .issue_valid_i, .issue_ready_o, .issue_instr_i, .issue_rs1_i,
    .issue_id_i, .issue_accept_o, .commit_valid_i, .clr_valid_o, .clr_ready_i,
    .clr_reg_o, .clr_row_o, .clr_data_o, .result_valid_o, .result_ready_i, .result_id_o
  );

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16 + x^14 + x^13 + x^11 + 1
  endfunction

  function automatic logic [31:0] next_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Legal words keep a random md and scalar, others may break opcode or funct3
  function automatic logic [31:0] make_instr(input logic legal);
    logic [31:0] w;
    w = next_bits(32);
    if (legal || next_bits(1) == 32'd1) w[6:0] = OPC_MATRIX;
    if (legal) w[14:12] = {2'b00, w[12]};
    return w;
  endfunction

  task automatic log_mismatch(input string sig, input logic [127:0] exp_v,
                              input logic [127:0] act_v);
    $display("[ERROR] %0t %s expected 0x%0h got 0x%0h", $time, sig, exp_v, act_v);
    errors++;
  endtask

  task automatic log_failure(input string what);
    $display("%0t %s", $time, what);
    errors++;
  endtask

  // ******************************
  // Model update
  // ******************************

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (clr_valid_o && clr_ready_i && md_qm.size() != 0) begin
        n_checks++;
        if (row_cnt == `MX_N_ROWS - 1) begin  // Last row of this register
          row_cnt = 0;
          void'(md_qm.pop_front());
          void'(data_qm.pop_front());
        end else begin
          row_cnt++;
        end
      end
      if (result_valid_o && result_ready_i && id_qm.size() != 0) begin
        n_checks++;
        void'(id_qm.pop_front());
        live_cnt--;
      end
      if (issue_valid_i) n_checks++;
      if (issue_valid_i && issue_ready_o && exp_accept) begin
        md_qm.push_back(issue_instr_i[9:7]);
        data_qm.push_back((issue_instr_i[14:12] == F3_BCAST) ? {rep{issue_rs1_i}} : row_t'(0));
        id_qm.push_back(issue_id_i);
        n_accepted++;
      end
      if (commit_valid_i) begin
        n_committed++;
        live_cnt++;
      end
      rows_pend  <= (md_qm.size() != 0);
      exp_md     <= (md_qm.size() != 0) ? md_qm[0] : '0;
      exp_data   <= (data_qm.size() != 0) ? data_qm[0] : '0;
      exp_row    <= row_idx_t'(row_cnt);
      res_pend   <= (id_qm.size() != 0);
      exp_id     <= (id_qm.size() != 0) ? id_qm[0] : '0;
      model_idle <= (live_cnt == 0);
    end
  end

  // ******************************
  // Checks
  // ******************************

  a_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_i |-> issue_accept_o == exp_accept)
    else log_mismatch("issue_accept_o", $sampled(exp_accept), $sampled(issue_accept_o));
  a_idle_clr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    model_idle |-> !clr_valid_o)
    else log_mismatch("clr_valid_o", 0, $sampled(clr_valid_o));
  a_idle_res: assert property (@(posedge clk_i) disable iff (!rst_ni)
    model_idle |-> !result_valid_o)
    else log_mismatch("result_valid_o", 0, $sampled(result_valid_o));
  a_row_owed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clr_valid_o && clr_ready_i |-> rows_pend)
    else log_failure("row write with no accepted instruction waiting for it");
  a_reg: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clr_valid_o && clr_ready_i && rows_pend |-> clr_reg_o == exp_md)
    else log_mismatch("clr_reg_o", $sampled(exp_md), $sampled(clr_reg_o));
  a_row: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clr_valid_o && clr_ready_i && rows_pend |-> clr_row_o == exp_row)
    else log_mismatch("clr_row_o", $sampled(exp_row), $sampled(clr_row_o));
  a_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clr_valid_o && clr_ready_i && rows_pend |-> clr_data_o == exp_data)
    else log_mismatch("clr_data_o", $sampled(exp_data), $sampled(clr_data_o));
  a_res_owed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid_o && result_ready_i |-> res_pend)
    else log_failure("result returned with no accepted instruction left");
  a_res_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_valid_o && result_ready_i && res_pend |-> result_id_o == exp_id)
    else log_mismatch("result_id_o", $sampled(exp_id), $sampled(result_id_o));

  // ******************************
  // Stimulus
  // ******************************

  // One falling edge, with commit and back-pressure drawn for the next cycle
  task automatic step();
    @(negedge clk_i);
    if (!issue_ready_o) saw_full = 1'b1;
    issue_valid_i  = 1'b0;
    commit_valid_i = commit_en && (n_accepted > n_committed) && (next_bits(2) != 0);
    case (bp_mode)
      0: begin
        clr_ready_i    = 1'b1;
        result_ready_i = 1'b1;
      end
      1: begin
        clr_ready_i    = next_bits(1) == 32'd1;
        result_ready_i = next_bits(1) == 32'd1;
      end
      default: begin
        clr_ready_i    = 1'b0;
        result_ready_i = 1'b0;
      end
    endcase
  endtask

  // Holds the offer until the buffer has room
  task automatic offer(input logic [31:0] instr, input logic [31:0] rs1);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      step();
      issue_valid_i = 1'b1;
      issue_instr_i = instr;
      issue_rs1_i   = rs1;
      issue_id_i    = id_ctr;
      exp_accept    = (instr[6:0] == OPC_MATRIX) &&
                      ((instr[14:12] == F3_ZERO) || (instr[14:12] == F3_BCAST));
      taken = issue_ready_o;
    end
    id_ctr++;
  endtask

  task automatic drain();
    while (md_qm.size() != 0 || id_qm.size() != 0 || n_committed != n_accepted) step();
  endtask

  task automatic finish_test(input string name);
    n_tests++;
    $display("test %0d %s finished, %0d errors so far", n_tests, name, errors);
  endtask

  initial begin
    rst_ni         = 1'b0;
    issue_valid_i  = 1'b0;
    issue_instr_i  = '0;
    issue_rs1_i    = '0;
    issue_id_i     = '0;
    commit_valid_i = 1'b0;
    clr_ready_i    = 1'b1;
    result_ready_i = 1'b1;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    step();
    n_checks++;
    assert (!clr_valid_o && !result_valid_o && issue_ready_o)
      else log_failure("outputs not in their idle state after reset");
    finish_test("reset");

    repeat (40) offer(make_instr(1'b0), next_bits(32));
    drain();
    finish_test("decode");

    commit_en = 1'b0;  // Nothing may move until committed
    repeat (3) offer(make_instr(1'b1), next_bits(32));
    repeat (20) step();
    commit_en = 1'b1;
    drain();
    finish_test("commit gate");

    bp_mode = 1;
    repeat (30) offer(make_instr(1'b1), next_bits(32));
    drain();
    finish_test("row fill");

    saw_full = 1'b0;
    bp_mode  = 2;
    repeat (5) offer(make_instr(1'b1), next_bits(32));
    repeat (10) step();
    n_checks++;
    assert (saw_full) else log_failure("issue_ready_o never fell with the buffer full");
    bp_mode = 1;
    repeat (20) offer(make_instr(1'b0), next_bits(32));
    drain();
    finish_test("back-pressure");

    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Generous bound per offer covers every stall the tests create
  initial begin
    #(n_instr * 200 * clk_period);
    $display("watchdog expired, the DUT stopped returning results");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+src
src/mx_pkg.sv
src/mx_issue_buffer.sv
src/mx_dispatcher.sv
src/mx_row_fill_unit.sv
src/mx_result_queue.sv
src/mx_top.sv
dv/tb_mx.sv

// ==== Makefile ====
# Verilator build and run for the matrix fill coprocessor

TOP := tb_mx

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
